// ==== src/loopback_cfg_pkg.sv ====
package loopback_cfg_pkg;

    // ##############################
    // stream geometry
    // ##############################

    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8; // one enable per byte

    // ##############################
    // port numbering and tags
    // ##############################

    localparam int PORT_COUNT = 2;
    localparam int FIRST_PORT = 2; // port i reports FIRST_PORT + i on tuser
    localparam int PORT_WIDTH = 2;

    // the tag carries a core index plus five bits of slot and flag information
    localparam int CORE_WIDTH = 4;
    localparam int TAG_WIDTH  = 5 + CORE_WIDTH;

    // ##############################
    // per-port buffering
    // ##############################

    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH); // depth is a power of two

endpackage

// ==== src/msg_hdr_pkg.sv ====
package msg_hdr_pkg;

    // ##############################
    // routing header
    // ##############################

    // the header is the whole first beat of a frame
    // its low bits hold the destination tag, the rest is ignored here
    localparam int HDR_WIDTH = 64;

    // ##############################
    // header remover FSM
    // ##############################

    typedef enum logic [0:0] {
        ST_HDR,  // waiting for the header beat of the next frame
        ST_BODY  // passing payload beats through with the latched tag
    } hdr_state_e;

endpackage

// ==== src/axis_if.sv ====
`timescale 1ns/100ps

interface axis_if import loopback_cfg_pkg::*; ();

    logic [DATA_WIDTH-1:0] tdata;
    logic [KEEP_WIDTH-1:0] tkeep;
    logic                  tlast;
    logic [TAG_WIDTH-1:0]  tdest;
    logic                  tvalid;
    logic                  tready;

    // the side that produces beats
    modport src (
        output tdata,
        output tkeep,
        output tlast,
        output tdest,
        output tvalid,
        input  tready
    );

    modport snk (
        input  tdata,
        input  tkeep,
        input  tlast,
        input  tdest,
        input  tvalid,
        output tready
    );

endinterface

// ==== src/header_remover.sv ====
`timescale 1ns/100ps

module header_remover
    import loopback_cfg_pkg::*, msg_hdr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic [DATA_WIDTH-1:0] s_axis_tdata,
    input  logic [KEEP_WIDTH-1:0] s_axis_tkeep,
    input  logic                  s_axis_tlast,
    input  logic                  s_axis_tvalid,
    output logic                  s_axis_tready,

    axis_if.src                   body
);

    hdr_state_e           state_q;
    logic [TAG_WIDTH-1:0] tag_q;
    logic [HDR_WIDTH-1:0] hdr_word;
    logic                 hdr_fire;
    logic                 body_fire;

    assign hdr_word = s_axis_tdata[HDR_WIDTH-1:0];

    assign hdr_fire  = (state_q == ST_HDR) && s_axis_tvalid;            // ready is always high here
    assign body_fire = (state_q == ST_BODY) && s_axis_tvalid && body.tready;

    // ##############################
    // handshake steering
    // ##############################

    // the header beat is swallowed, payload beats pass straight through
    always_comb begin
        s_axis_tready = 1'b1;
        body.tvalid   = 1'b0;
        if (state_q == ST_BODY) begin
            s_axis_tready = body.tready;
            body.tvalid   = s_axis_tvalid;
        end
    end

    assign body.tdata = s_axis_tdata;
    assign body.tkeep = s_axis_tkeep;
    assign body.tlast = s_axis_tlast;
    assign body.tdest = tag_q;

    // ##############################
    // state and tag
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_HDR;
        end else begin
            case (state_q)
                ST_HDR: begin
                    // a header beat with tlast is a frame with no payload
                    if (hdr_fire && !s_axis_tlast) begin
                        state_q <= ST_BODY;
                    end
                end
                ST_BODY: begin
                    if (body_fire && s_axis_tlast) begin
                        state_q <= ST_HDR;
                    end
                end
                default: state_q <= ST_HDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            tag_q <= hdr_word[TAG_WIDTH-1:0]; // low header bits become tdest
        end
    end

    // every payload beat of a frame must carry the same tag
    a_tag_stable_in_body : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == ST_BODY) |=> $stable(tag_q)
    ) else $error("tag changed in the middle of a frame");

endmodule

// ==== src/axis_fifo.sv ====
`timescale 1ns/100ps

module axis_fifo
    import loopback_cfg_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    axis_if.snk  s,
    axis_if.src  m
);

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        logic [TAG_WIDTH-1:0]  dest;
    } entry_t;

    entry_t                     mem [FIFO_DEPTH];
    entry_t                     out_q;
    logic                       out_valid_q;

    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr_q;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr_q;
    logic [FIFO_ADDR_WIDTH:0]   count_q;  // beats in memory, not counting the output register

    logic                       full;
    logic                       wr_en;
    logic                       rd_en;

    assign full  = (count_q == (FIFO_ADDR_WIDTH+1)'(FIFO_DEPTH));
    assign wr_en = s.tvalid && s.tready;
    // refill whenever the output register is empty or is being emptied this cycle
    assign rd_en = (count_q != '0) && (!out_valid_q || m.tready);

    assign s.tready = !full;

    // ##############################
    // storage
    // ##############################

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= '{data: s.tdata, keep: s.tkeep, last: s.tlast, dest: s.tdest};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1; // wraps, depth is 2**addr width
            if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ##############################
    // registered output
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else if (rd_en) begin
            out_valid_q <= 1'b1;
        end else if (m.tready) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_q <= mem[rd_ptr_q];
        end
    end

    assign m.tvalid = out_valid_q;
    assign m.tdata  = out_q.data;
    assign m.tkeep  = out_q.keep;
    assign m.tlast  = out_q.last;
    assign m.tdest  = out_q.dest;

    // a full FIFO must leave its write side untouched
    a_no_write_when_full : assert property (
        @(posedge clk) disable iff (!rst_n)
        full |=> $stable(wr_ptr_q)
    ) else $error("write pointer moved while the FIFO was full");

    // a stalled beat has to wait in place
    a_hold_under_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        (m.tvalid && !m.tready) |=> (m.tvalid && $stable(out_q))
    ) else $error("output beat dropped or changed while stalled");

endmodule

// ==== src/loopback_msg_fifo.sv ====
`timescale 1ns/100ps

module loopback_msg_fifo
    import loopback_cfg_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic [PORT_COUNT*DATA_WIDTH-1:0] s_axis_tdata,
    input  logic [PORT_COUNT*KEEP_WIDTH-1:0] s_axis_tkeep,
    input  logic [PORT_COUNT-1:0]            s_axis_tvalid,
    input  logic [PORT_COUNT-1:0]            s_axis_tlast,
    output logic [PORT_COUNT-1:0]            s_axis_tready,

    output logic [PORT_COUNT*DATA_WIDTH-1:0] m_axis_tdata,
    output logic [PORT_COUNT*KEEP_WIDTH-1:0] m_axis_tkeep,
    output logic [PORT_COUNT-1:0]            m_axis_tvalid,
    output logic [PORT_COUNT-1:0]            m_axis_tlast,
    output logic [PORT_COUNT*TAG_WIDTH-1:0]  m_axis_tdest,
    output logic [PORT_COUNT*PORT_WIDTH-1:0] m_axis_tuser,
    input  logic [PORT_COUNT-1:0]            m_axis_tready
);

    // ##############################
    // one independent lane per port
    // ##############################

    for (genvar i = 0; i < PORT_COUNT; i++) begin : g_port

        axis_if body_if ();  // remover to FIFO
        axis_if out_if ();   // FIFO to the flat output slice

        header_remover i_hdr_remover (
            .clk           (clk),
            .rst_n         (rst_n),
            .s_axis_tdata  (s_axis_tdata[i*DATA_WIDTH +: DATA_WIDTH]),
            .s_axis_tkeep  (s_axis_tkeep[i*KEEP_WIDTH +: KEEP_WIDTH]),
            .s_axis_tlast  (s_axis_tlast[i]),
            .s_axis_tvalid (s_axis_tvalid[i]),
            .s_axis_tready (s_axis_tready[i]),
            .body          (body_if)
        );

        axis_fifo i_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .s     (body_if),
            .m     (out_if)
        );

        assign m_axis_tdata[i*DATA_WIDTH +: DATA_WIDTH] = out_if.tdata;
        assign m_axis_tkeep[i*KEEP_WIDTH +: KEEP_WIDTH] = out_if.tkeep;
        assign m_axis_tdest[i*TAG_WIDTH +: TAG_WIDTH]   = out_if.tdest;
        assign m_axis_tvalid[i]                         = out_if.tvalid;
        assign m_axis_tlast[i]                          = out_if.tlast;
        assign out_if.tready                            = m_axis_tready[i];

        // the source port number is fixed per lane
        assign m_axis_tuser[i*PORT_WIDTH +: PORT_WIDTH] = PORT_WIDTH'(FIRST_PORT + i);

    end

endmodule

// ==== dv/loopback_checker.sv ====
`timescale 1ns/100ps

module loopback_checker
    import loopback_cfg_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [PORT_COUNT*DATA_WIDTH-1:0] s_axis_tdata,
    input  logic [PORT_COUNT*KEEP_WIDTH-1:0] s_axis_tkeep,
    input  logic [PORT_COUNT-1:0]            s_axis_tvalid,
    input  logic [PORT_COUNT-1:0]            s_axis_tlast,
    input  logic [PORT_COUNT-1:0]            s_axis_tready,
    input  logic [PORT_COUNT*DATA_WIDTH-1:0] m_axis_tdata,
    input  logic [PORT_COUNT*KEEP_WIDTH-1:0] m_axis_tkeep,
    input  logic [PORT_COUNT-1:0]            m_axis_tvalid,
    input  logic [PORT_COUNT-1:0]            m_axis_tlast,
    input  logic [PORT_COUNT*TAG_WIDTH-1:0]  m_axis_tdest,
    input  logic [PORT_COUNT*PORT_WIDTH-1:0] m_axis_tuser,
    input  logic [PORT_COUNT-1:0]            m_axis_tready,
    input  logic                             done,
    output int                               error_count,
    output int                               missing_count,
    output int                               pending_count
);

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        logic [TAG_WIDTH-1:0]  dest;
    } beat_t;

    beat_t                 expect_q [PORT_COUNT][$];  // payload beats still owed per port
    logic [PORT_COUNT-1:0] in_body;
    logic [TAG_WIDTH-1:0]  tag [PORT_COUNT];
    logic                  seen_input;
    logic                  reported;

    always @(posedge clk) begin : monitor
        beat_t got;
        beat_t want;
        int    want_port;
        if (!rst_n) begin
            in_body    = '0;
            seen_input = 1'b0;
            reported   = 1'b0;
            for (int p = 0; p < PORT_COUNT; p++) expect_q[p].delete();
        end else begin
            // until the first input beat the block has to sit idle and ready
            if (!seen_input) begin
                if (m_axis_tvalid != '0 || s_axis_tready != '1) begin
                    error_count++;
                    $display("CHECK FAILED @ %0t: idle after reset, m_axis_tvalid=%b s_axis_tready=%b",
                             $time, m_axis_tvalid, s_axis_tready);
                end
                if (s_axis_tvalid != '0) seen_input = 1'b1;
            end

            for (int p = 0; p < PORT_COUNT; p++) begin
                // ##############################
                // header strip model
                // ##############################
                if (s_axis_tvalid[p] && s_axis_tready[p]) begin
                    if (!in_body[p]) begin
                        tag[p]     = s_axis_tdata[p*DATA_WIDTH +: TAG_WIDTH];
                        in_body[p] = !s_axis_tlast[p]; // header-only frames end here
                    end else begin
                        expect_q[p].push_back('{s_axis_tdata[p*DATA_WIDTH +: DATA_WIDTH],
                                                s_axis_tkeep[p*KEEP_WIDTH +: KEEP_WIDTH],
                                                s_axis_tlast[p], tag[p]});
                        if (s_axis_tlast[p]) in_body[p] = 1'b0;
                    end
                end

                if (m_axis_tvalid[p]) begin
                    want_port = FIRST_PORT + p;
                    if (int'(m_axis_tuser[p*PORT_WIDTH +: PORT_WIDTH]) != want_port) begin
                        error_count++;
                        $display("CHECK FAILED @ %0t: port %0d tuser=%0d, expected %0d", $time, p,
                                 m_axis_tuser[p*PORT_WIDTH +: PORT_WIDTH], want_port);
                    end
                end

                if (m_axis_tvalid[p] && m_axis_tready[p]) begin
                    got = '{m_axis_tdata[p*DATA_WIDTH +: DATA_WIDTH],
                            m_axis_tkeep[p*KEEP_WIDTH +: KEEP_WIDTH],
                            m_axis_tlast[p], m_axis_tdest[p*TAG_WIDTH +: TAG_WIDTH]};
                    if (expect_q[p].size() == 0) begin
                        error_count++;
                        $display("port %0d sent an output beat at %0t that no input frame explains",
                                 p, $time);
                    end else begin
                        want = expect_q[p].pop_front();
                        if (got !== want) begin
                            error_count++;
                            $display("CHECK FAILED @ %0t: port %0d got data=%h keep=%h last=%b dest=%h",
                                     $time, p, got.data, got.keep, got.last, got.dest);
                            $display("    expected data=%h keep=%h last=%b dest=%h",
                                     want.data, want.keep, want.last, want.dest);
                        end
                    end
                end
            end

            pending_count = 0;
            for (int p = 0; p < PORT_COUNT; p++) pending_count += expect_q[p].size();

            if (done && !reported) begin
                reported = 1'b1;
                for (int p = 0; p < PORT_COUNT; p++) begin
                    if (expect_q[p].size() != 0) begin
                        $display("port %0d still owes %0d payload beats that never came out",
                                 p, expect_q[p].size());
                        missing_count += expect_q[p].size();
                    end
                end
            end
        end
    end

endmodule

// ==== dv/loopback_tb.sv ====
`timescale 1ns/100ps

module loopback_tb
    import loopback_cfg_pkg::*;
();

    localparam int FRAME_COUNT  = 12;
    localparam int DRAIN_CYCLES = 8 * FIFO_DEPTH;

    typedef struct {
        int                    port;
        logic [DATA_WIDTH-1:0] hdr;
        int                    len;        // payload beats, 0 is a header-only frame
        logic [KEEP_WIDTH-1:0] last_keep;
        bit                    bp;         // random output back-pressure while sending
    } frame_t;

    logic                             clk = 1'b0;
    logic                             rst_n;
    logic [PORT_COUNT*DATA_WIDTH-1:0] s_axis_tdata;
    logic [PORT_COUNT*KEEP_WIDTH-1:0] s_axis_tkeep;
    logic [PORT_COUNT-1:0]            s_axis_tvalid;
    logic [PORT_COUNT-1:0]            s_axis_tlast;
    logic [PORT_COUNT-1:0]            s_axis_tready;
    logic [PORT_COUNT*DATA_WIDTH-1:0] m_axis_tdata;
    logic [PORT_COUNT*KEEP_WIDTH-1:0] m_axis_tkeep;
    logic [PORT_COUNT-1:0]            m_axis_tvalid;
    logic [PORT_COUNT-1:0]            m_axis_tlast;
    logic [PORT_COUNT*TAG_WIDTH-1:0]  m_axis_tdest;
    logic [PORT_COUNT*PORT_WIDTH-1:0] m_axis_tuser;
    logic [PORT_COUNT-1:0]            m_axis_tready;
    logic                             done;
    logic [PORT_COUNT-1:0]            bp_on;
    int                               error_count;
    int                               missing_count;
    int                               pending_count;
    int                               watchdog_ns;
    frame_t                           frames [FRAME_COUNT];

    always #20 clk = ~clk;

    loopback_msg_fifo i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tdest  (m_axis_tdest),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tready (m_axis_tready)
    );

    loopback_checker i_checker (.*);

    // output ready toggles at random only on ports with back-pressure enabled
    always @(posedge clk) begin
        #2;
        for (int p = 0; p < PORT_COUNT; p++) begin
            m_axis_tready[p] = bp_on[p] ? 1'($urandom % 2) : 1'b1;
        end
    end

    // ##############################
    // frame table
    // ##############################

    task automatic load_frames();
        frames[0]  = '{0, 64'h1111_2222_3333_41a5, 3,  8'hff, 1'b0};
        frames[1]  = '{1, 64'hfeed_0000_0000_0033, 1,  8'h0f, 1'b0};
        frames[2]  = '{0, 64'h0000_0000_0000_01ff, 0,  8'hff, 1'b0};
        frames[3]  = '{0, 64'h8000_0000_0000_0001, 2,  8'h01, 1'b0};
        frames[4]  = '{1, 64'h0000_0000_0000_0100, 0,  8'hff, 1'b0};
        frames[5]  = '{1, 64'h5a5a_5a5a_5a5a_5e5a, 4,  8'h3f, 1'b0};
        frames[6]  = '{0, 64'hdead_beef_0000_0122, 40, 8'hff, 1'b1};  // overruns the FIFO
        frames[7]  = '{1, 64'h0123_4567_89ab_cdef, 9,  8'h7f, 1'b0};
        frames[8]  = '{1, 64'h0000_0000_0000_0000, 24, 8'h80, 1'b1};
        frames[9]  = '{0, 64'hffff_ffff_ffff_fe00, 5,  8'h03, 1'b0};
        frames[10] = '{0, 64'h0000_0000_0000_0077, 1,  8'hff, 1'b0};
        frames[11] = '{1, 64'h7777_0000_0000_00c4, 20, 8'hff, 1'b0};
    endtask

    function automatic int count_beats();
        int total;
        total = 0;
        for (int f = 0; f < FRAME_COUNT; f++) total += frames[f].len + 1;
        return total;
    endfunction

    // called 2 ns after an edge, returns 2 ns after the edge that moved the beat
    task automatic send_beat(input int p, input logic [DATA_WIDTH-1:0] data,
                             input logic [KEEP_WIDTH-1:0] keep, input logic last);
        logic ready;
        s_axis_tdata[p*DATA_WIDTH +: DATA_WIDTH] = data;
        s_axis_tkeep[p*KEEP_WIDTH +: KEEP_WIDTH] = keep;
        s_axis_tlast[p]  = last;
        s_axis_tvalid[p] = 1'b1;
        do begin
            @(negedge clk);
            ready = s_axis_tready[p];  // nothing changes again before the rising edge
            @(posedge clk);
        end while (!ready);
        #2;
    endtask

    task automatic drive_port(input int p);
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        for (int f = 0; f < FRAME_COUNT; f++) begin
            if (frames[f].port == p) begin
                bp_on[p] = frames[f].bp;
                send_beat(p, frames[f].hdr, '1, frames[f].len == 0);
                for (int b = 0; b < frames[f].len; b++) begin
                    data = {$urandom, $urandom};
                    keep = (b == frames[f].len - 1) ? frames[f].last_keep : '1;
                    send_beat(p, data, keep, b == frames[f].len - 1);
                end
                s_axis_tvalid[p] = 1'b0;  // one idle cycle between frames
                @(posedge clk);
                #2;
            end
        end
        bp_on[p] = 1'b0;
    endtask

    // ##############################
    // main sequence
    // ##############################

    initial begin
        void'($urandom(32'hd96a_b0f2));
        rst_n         = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tvalid = '0;
        s_axis_tlast  = '0;
        m_axis_tready = '1;
        bp_on         = '0;
        done          = 1'b0;
        load_frames();
        watchdog_ns = count_beats() * 8 * 40 + 2000;

        fork
            begin
                #(watchdog_ns);
                $display("timeout: the run did not finish within %0d ns", watchdog_ns);
                $display("TEST FAILED");
                $finish;
            end
        join_none

        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (3) @(posedge clk);  // idle cycles so the checker sees the reset state
        #2;

        fork
            drive_port(0);
            drive_port(1);
        join

        // the FIFOs get a bounded time to hand out what they still hold
        for (int c = 0; c < DRAIN_CYCLES && pending_count != 0; c++) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);  // room for any stray extra beat to show up
        #2 done = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        $display("closing report: %0d value errors, %0d beats never delivered",
                 error_count, missing_count);
        if (error_count == 0 && missing_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/loopback_cfg_pkg.sv
src/msg_hdr_pkg.sv
src/axis_if.sv
src/header_remover.sv
src/axis_fifo.sv
src/loopback_msg_fifo.sv
dv/loopback_checker.sv
dv/loopback_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the loopback testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module loopback_tb \
    -Mdir obj_dir -o loopback_sim \
    -f list.f

./obj_dir/loopback_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
